//--- include/ps2_config.svh
// ======================================================================
// PS/2 input block constants
// input filter depth, frame timeout and pointer screen limits
// ======================================================================

`ifndef PS2_CONFIG_SVH
`define PS2_CONFIG_SVH

// equal clk samples before a new PS/2 clock level is taken
`define PS2_FILTER_LEN 8

// clk cycles without a falling PS/2 clock edge before a partial frame is dropped
// a slow device bit period is about 2500 cycles at 25 MHz
`define PS2_TIMEOUT 6000

// largest pointer coordinates
`define MS_X_MAX 1023
`define MS_Y_MAX 767

`endif

//--- source/ps2_pkg.sv
// ======================================================================
// PS/2 input block types
// byte, key event and mouse report records, FSM states
// ======================================================================

`default_nettype none

package ps2_pkg;

   // one received frame
   typedef struct packed {
      logic       valid;   // one-cycle strobe
      logic       err;     // parity or stop bit bad
      logic [7:0] data;
   } ps2_byte_t;

   // one decoded key
   typedef struct packed {
      logic       valid;
      logic       released;   // F0 seen before code
      logic       extended;   // E0 seen before code
      logic [7:0] code;
   } kbd_event_t;

   // one stream-mode mouse packet
   typedef struct packed {
      logic              valid;
      logic [2:0]        buttons;   // middle, right, left
      logic signed [8:0] dx;
      logic signed [8:0] dy;        // positive is up
   } ms_report_t;

   // frame receiver
   typedef enum logic [1:0] {
      rx_idle,
      rx_data,
      rx_parity,
      rx_stop
   } rx_state_e;

   // position inside a mouse packet
   typedef enum logic [1:0] {
      ms_byte0,
      ms_byte1,
      ms_byte2
   } ms_phase_e;

endpackage

`default_nettype wire

//--- source/ps2_rx.sv
// ======================================================================
// PS/2 device-to-host frame receiver
// synchronises and filters the PS/2 clock, shifts in start, 8 data,
// odd parity and stop, and drops frames that stall
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

`include "ps2_config.svh"

module ps2_rx (
   input  wire logic          clk,
   input  wire logic          reset,
   input  wire logic          ps2_clk_in,
   input  wire logic          ps2_data_in,
   output ps2_pkg::ps2_byte_t rx
);
   import ps2_pkg::*;

   localparam int filt_w = $clog2(`PS2_FILTER_LEN + 1);
   localparam int tmo_w  = $clog2(`PS2_TIMEOUT + 1);
   localparam logic [filt_w-1:0] filt_last = filt_w'(`PS2_FILTER_LEN - 1);
   localparam logic [tmo_w-1:0]  tmo_last  = tmo_w'(`PS2_TIMEOUT - 1);

   logic [1:0]        clk_sync;
   logic [1:0]        data_sync;
   logic              clk_filt;    // accepted PS/2 clock level
   logic [filt_w-1:0] filt_cnt;
   logic              fall;        // accepted falling edge
   rx_state_e         state;
   logic [2:0]        bit_cnt;
   logic [7:0]        shift;
   logic              par_bit;
   logic [tmo_w-1:0]  tmo_cnt;

   // two-flop synchronisers, lines idle high
   always_ff @(posedge clk) begin
      if (reset) begin
         clk_sync  <= 2'b11;
         data_sync <= 2'b11;
      end else begin
         clk_sync  <= {clk_sync[0], ps2_clk_in};
         data_sync <= {data_sync[0], ps2_data_in};
      end
   end

   // level only moves after filt_len differing samples in a row
   always_ff @(posedge clk) begin
      if (reset) begin
         clk_filt <= 1'b1;
         filt_cnt <= '0;
      end else if (clk_sync[1] == clk_filt) begin
         filt_cnt <= '0;
      end else if (filt_cnt == filt_last) begin
         clk_filt <= clk_sync[1];
         filt_cnt <= '0;
      end else begin
         filt_cnt <= filt_cnt + 1'b1;
      end
   end

   assign fall = clk_filt && !clk_sync[1] && (filt_cnt == filt_last);

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= rx_idle;
         bit_cnt  <= '0;
         tmo_cnt  <= '0;
         rx.valid <= 1'b0;
      end else begin
         rx.valid <= 1'b0;

         if (state == rx_idle || fall)
            tmo_cnt <= '0;
         else
            tmo_cnt <= tmo_cnt + 1'b1;

         case (state)
            rx_idle: begin
               if (fall && !data_sync[1]) begin   // start bit
                  state   <= rx_data;
                  bit_cnt <= '0;
               end
            end
            rx_data: begin
               if (fall) begin
                  shift   <= {data_sync[1], shift[7:1]};   // lsb first
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7)
                     state <= rx_parity;
               end
            end
            rx_parity: begin
               if (fall) begin
                  par_bit <= data_sync[1];
                  state   <= rx_stop;
               end
            end
            rx_stop: begin
               if (fall) begin
                  rx.valid <= 1'b1;
                  rx.data  <= shift;
                  // odd parity over data and parity bit, stop must be high
                  rx.err   <= !(^{par_bit, shift}) || !data_sync[1];
                  state    <= rx_idle;
               end
            end
            default: state <= rx_idle;
         endcase

         // device went quiet mid frame
         if (state != rx_idle && !fall && tmo_cnt == tmo_last)
            state <= rx_idle;
      end
   end

endmodule

`default_nettype wire

//--- source/kbd_decoder.sv
// ======================================================================
// Keyboard path
// scan code set 2 bytes to key events, folding the F0 release and
// E0 extended prefixes into the following code
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module kbd_decoder (
   input  wire logic           clk,
   input  wire logic           reset,
   input  wire logic           ps2_clk_in,
   input  wire logic           ps2_data_in,
   output ps2_pkg::kbd_event_t kbd_event
);
   import ps2_pkg::*;

   localparam logic [7:0] code_release = 8'hf0;
   localparam logic [7:0] code_extend  = 8'he0;

   ps2_byte_t rx;
   logic      rel_pend;   // F0 seen, code still to come
   logic      ext_pend;   // E0 seen

   ps2_rx rx_i (
      .clk         (clk),
      .reset       (reset),
      .ps2_clk_in  (ps2_clk_in),
      .ps2_data_in (ps2_data_in),
      .rx          (rx)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         rel_pend        <= 1'b0;
         ext_pend        <= 1'b0;
         kbd_event.valid <= 1'b0;
      end else begin
         kbd_event.valid <= 1'b0;
         if (rx.valid) begin
            if (rx.err) begin
               // lost byte, prefixes no longer trustworthy
               rel_pend <= 1'b0;
               ext_pend <= 1'b0;
            end else if (rx.data == code_release) begin
               rel_pend <= 1'b1;
            end else if (rx.data == code_extend) begin
               ext_pend <= 1'b1;
            end else begin
               kbd_event.valid    <= 1'b1;
               kbd_event.released <= rel_pend;
               kbd_event.extended <= ext_pend;
               kbd_event.code     <= rx.data;
               rel_pend           <= 1'b0;
               ext_pend           <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- source/mouse_tracker.sv
// ======================================================================
// Mouse path
// assembles three-byte stream mode packets into movement reports,
// resyncs on the always-one bit of the first byte
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module mouse_tracker (
   input  wire logic           clk,
   input  wire logic           reset,
   input  wire logic           ps2_clk_in,
   input  wire logic           ps2_data_in,
   output ps2_pkg::ms_report_t report
);
   import ps2_pkg::*;

   ps2_byte_t  rx;
   ms_phase_e  phase;
   logic [7:0] head;   // byte0: ovf y, ovf x, sign y, sign x, 1, buttons
   logic [7:0] dx_lo;  // byte1

   // 9-bit two's complement delta, zero when the axis overflowed
   function automatic logic signed [8:0] delta(
      input logic       ovf,
      input logic       sign,
      input logic [7:0] mag
   );
      logic signed [8:0] d;
      d = ovf ? 9'sd0 : $signed({sign, mag});
      return d;
   endfunction

   ps2_rx rx_i (
      .clk         (clk),
      .reset       (reset),
      .ps2_clk_in  (ps2_clk_in),
      .ps2_data_in (ps2_data_in),
      .rx          (rx)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         phase        <= ms_byte0;
         report.valid <= 1'b0;
      end else begin
         report.valid <= 1'b0;
         if (rx.valid) begin
            if (rx.err) begin
               phase <= ms_byte0;   // start over on next header
            end else begin
               case (phase)
                  ms_byte0: begin
                     if (rx.data[3]) begin   // else stray byte, stay here
                        head  <= rx.data;
                        phase <= ms_byte1;
                     end
                  end
                  ms_byte1: begin
                     dx_lo <= rx.data;
                     phase <= ms_byte2;
                  end
                  ms_byte2: begin
                     report.valid   <= 1'b1;
                     report.buttons <= head[2:0];
                     report.dx      <= delta(head[6], head[4], dx_lo);
                     report.dy      <= delta(head[7], head[5], rx.data);
                     phase          <= ms_byte0;
                  end
                  default: phase <= ms_byte0;
               endcase
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- source/kbms_regs.sv
// ======================================================================
// Keyboard and mouse CPU registers
// key code word, saturating pointer position and ready strobes
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

`include "ps2_config.svh"

module kbms_regs (
   input  wire logic                clk,
   input  wire logic                reset,
   input  wire ps2_pkg::kbd_event_t kbd_event,
   input  wire ps2_pkg::ms_report_t ms_report,
   output logic [15:0]              kb_data,
   output logic                     kb_ready,
   output logic [11:0]              ms_x,
   output logic [11:0]              ms_y,
   output logic [2:0]               ms_button,
   output logic                     ms_ready
);

   localparam logic signed [13:0] x_max = 14'(`MS_X_MAX);
   localparam logic signed [13:0] y_max = 14'(`MS_Y_MAX);

   logic signed [13:0] x_sum;
   logic signed [13:0] y_sum;
   logic [11:0]        x_next;
   logic [11:0]        y_next;

   // screen y grows downward, mouse dy grows upward
   always_comb begin
      x_sum = $signed({2'b00, ms_x}) + {{5{ms_report.dx[8]}}, ms_report.dx};
      y_sum = $signed({2'b00, ms_y}) - {{5{ms_report.dy[8]}}, ms_report.dy};

      if (x_sum < 14'sd0)
         x_next = '0;
      else if (x_sum > x_max)
         x_next = x_max[11:0];
      else
         x_next = x_sum[11:0];

      if (y_sum < 14'sd0)
         y_next = '0;
      else if (y_sum > y_max)
         y_next = y_max[11:0];
      else
         y_next = y_sum[11:0];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         kb_data   <= '0;
         kb_ready  <= 1'b0;
         ms_x      <= '0;
         ms_y      <= '0;
         ms_button <= '0;
         ms_ready  <= 1'b0;
      end else begin
         kb_ready <= kbd_event.valid;
         ms_ready <= ms_report.valid;
         if (kbd_event.valid)   // release in 15, extended in 8
            kb_data <= {kbd_event.released, 6'b0, kbd_event.extended, kbd_event.code};
         if (ms_report.valid) begin
            ms_x      <= x_next;
            ms_y      <= y_next;
            ms_button <= ms_report.buttons;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/ps2_support.sv
// ======================================================================
// PS/2 input block
// keyboard and mouse receive paths feeding the CPU-facing registers
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module ps2_support (
   input  wire logic   clk,
   input  wire logic   reset,
   input  wire logic   kb_ps2_clk_in,
   input  wire logic   kb_ps2_data_in,
   input  wire logic   ms_ps2_clk_in,
   input  wire logic   ms_ps2_data_in,
   output logic [15:0] kb_data,
   output logic        kb_ready,
   output logic [11:0] ms_x,
   output logic [11:0] ms_y,
   output logic [2:0]  ms_button,
   output logic        ms_ready
);
   import ps2_pkg::*;

   kbd_event_t kbd_event;
   ms_report_t ms_report;

   kbd_decoder kbd_i (
      .clk         (clk),
      .reset       (reset),
      .ps2_clk_in  (kb_ps2_clk_in),
      .ps2_data_in (kb_ps2_data_in),
      .kbd_event   (kbd_event)
   );

   mouse_tracker mouse_i (
      .clk         (clk),
      .reset       (reset),
      .ps2_clk_in  (ms_ps2_clk_in),
      .ps2_data_in (ms_ps2_data_in),
      .report      (ms_report)
   );

   kbms_regs regs_i (
      .clk       (clk),
      .reset     (reset),
      .kbd_event (kbd_event),
      .ms_report (ms_report),
      .kb_data   (kb_data),
      .kb_ready  (kb_ready),
      .ms_x      (ms_x),
      .ms_y      (ms_y),
      .ms_button (ms_button),
      .ms_ready  (ms_ready)
   );

endmodule

`default_nettype wire

//--- verification/ps2_support_tb.sv
// ======================================================================
// PS/2 input block testbench
// serialises keyboard and mouse frames from a table, checks kb_data,
// the pointer registers and the ready strobes
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

`include "ps2_config.svh"

module ps2_support_tb;

   localparam logic [1:0] dev_kb    = 2'd0;
   localparam logic [1:0] dev_ms    = 2'd1;
   localparam logic [1:0] dev_both  = 2'd2;   // keyboard code during a mouse packet
   localparam logic [1:0] no_fault  = 2'd0;
   localparam logic [1:0] bad_par   = 2'd1;
   localparam logic [1:0] truncated = 2'd2;   // last frame stops after five bits
   // three slow frames with tail and gap, then a quiet window
   localparam int row_cycles = 3 * (24 * 61 + 61) + `PS2_TIMEOUT + 300;

   typedef struct packed {
      logic [1:0]  dev;
      logic [1:0]  fault;     // hits the last byte only
      logic        strobe;    // ready pulse expected
      logic [1:0]  nb;
      logic [23:0] bytes;     // first byte in the top bits
      logic [7:0]  kb_byte;   // sent alongside a mouse packet
      logic [15:0] kb_exp;
   } row_t;

   logic        clk;
   logic        reset = 1'b1;
   logic        kb_ps2_clk = 1'b1;   // lines idle high
   logic        kb_ps2_data = 1'b1;
   logic        ms_ps2_clk = 1'b1;
   logic        ms_ps2_data = 1'b1;
   logic [15:0] kb_data;
   logic        kb_ready;
   logic [11:0] ms_x;
   logic [11:0] ms_y;
   logic [2:0]  ms_button;
   logic        ms_ready;

   row_t        rows[$];
   logic        rows_loaded = 1'b0;
   int          kb_count = 0;
   int          ms_count = 0;
   logic [15:0] kb_seen;
   logic [11:0] x_seen;
   logic [11:0] y_seen;
   logic [2:0]  btn_seen;
   int          model_x = 0;         // reference pointer position
   int          model_y = 0;
   logic [2:0]  model_btn = '0;

   ps2_support dut_i (
      .clk            (clk),
      .reset          (reset),
      .kb_ps2_clk_in  (kb_ps2_clk),
      .kb_ps2_data_in (kb_ps2_data),
      .ms_ps2_clk_in  (ms_ps2_clk),
      .ms_ps2_data_in (ms_ps2_data),
      .kb_data        (kb_data),
      .kb_ready       (kb_ready),
      .ms_x           (ms_x),
      .ms_y           (ms_y),
      .ms_button      (ms_button),
      .ms_ready       (ms_ready)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // capture each ready pulse away from the active edge
   always @(negedge clk) begin
      if (kb_ready) begin
         kb_count++;
         kb_seen = kb_data;
      end
      if (ms_ready) begin
         ms_count++;
         x_seen   = ms_x;
         y_seen   = ms_y;
         btn_seen = ms_button;
      end
   end

   task automatic abort_run(input string msg);
      $display("error at %0t: %s", $time, msg);
      $display("Test failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_equal(input logic [31:0] act, input logic [31:0] exp, input string what);
      if (act !== exp) begin
         $display("mismatch at %0t: %s got %0d (%0h), expected %0d (%0h)",
                  $time, what, act, act, exp, exp);
         $display("Test failed");
         $fatal(1, "value check");
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic drive_pins(input logic [1:0] dev, input logic c, input logic d);
      @(posedge clk);
      if (dev == dev_kb) begin
         kb_ps2_clk  <= c;
         kb_ps2_data <= d;
      end else begin
         ms_ps2_clk  <= c;
         ms_ps2_data <= d;
      end
   endtask

   // device to host frame, data moves while the clock is high
   task automatic send_frame(input logic [1:0] dev, input logic [7:0] b,
                             input logic [1:0] fault, input int half);
      logic        par;
      logic [10:0] bits;
      int          nbits;
      par = ~^b;   // odd parity
      if (fault == bad_par)
         par = ~par;
      bits  = {1'b1, par, b, 1'b0};
      nbits = (fault == truncated) ? 5 : 11;
      for (int k = 0; k < nbits; k++) begin
         drive_pins(dev, 1'b1, bits[k]);
         wait_cycles(half);
         drive_pins(dev, 1'b0, bits[k]);
         wait_cycles(half);
      end
      drive_pins(dev, 1'b1, 1'b1);
      wait_cycles(half);
   endtask

   task automatic send_bytes(input logic [1:0] dev, input row_t r, input int half);
      for (int i = 0; i < int'(r.nb); i++) begin
         send_frame(dev, r.bytes[23 - 8 * i -: 8],
                    (i == int'(r.nb) - 1) ? r.fault : no_fault, half);
         wait_cycles(30 + int'($urandom % 31));   // gap between frames
      end
   endtask

   task automatic send_row(input row_t r);
      int half;
      int kb_half;
      half    = 30 + int'($urandom % 31);
      kb_half = 30 + int'($urandom % 31);
      if (r.dev == dev_both) begin
         fork
            send_frame(dev_kb, r.kb_byte, no_fault, kb_half);
            send_bytes(dev_ms, r, half);
         join
      end else begin
         send_bytes(r.dev, r, half);
      end
   endtask

   task automatic wait_strobe(input logic [1:0] dev, input int base);
      int n;
      n = 0;
      while (((dev == dev_kb) ? kb_count : ms_count) == base && n < 300) begin
         @(posedge clk);
         n++;
      end
      if (((dev == dev_kb) ? kb_count : ms_count) == base) begin
         if (dev == dev_kb)
            abort_run("kb_ready never came after a complete key code");
         else
            abort_run("ms_ready never came after a complete mouse packet");
      end
   endtask

   function automatic int clamp(input int v, input int hi);
      return (v < 0) ? 0 : ((v > hi) ? hi : v);
   endfunction

   // stream packet rules, overflow zeroes an axis, screen y grows down
   task automatic model_move(input logic [23:0] pkt);
      logic [7:0] head;
      int         dx;
      int         dy;
      head      = pkt[23:16];
      dx        = head[6] ? 0 : int'(pkt[15:8]) - (head[4] ? 256 : 0);
      dy        = head[7] ? 0 : int'(pkt[7:0]) - (head[5] ? 256 : 0);
      model_x   = clamp(model_x + dx, `MS_X_MAX);
      model_y   = clamp(model_y - dy, `MS_Y_MAX);
      model_btn = head[2:0];
   endtask

   task automatic push_row(input row_t r);
      rows.push_back(r);
   endtask

   initial begin
      row_t r;
      int   kb_base;
      int   ms_base;
      void'($urandom(97));

      // keyboard make, release, extended, then no leak into a plain code
      push_row({dev_kb, no_fault, 1'b1, 2'd1, 24'h1c0000, 8'h00, 16'h001c});
      push_row({dev_kb, no_fault, 1'b1, 2'd2, 24'hf01c00, 8'h00, 16'h801c});
      push_row({dev_kb, no_fault, 1'b1, 2'd2, 24'he07500, 8'h00, 16'h0175});
      push_row({dev_kb, no_fault, 1'b1, 2'd3, 24'he0f075, 8'h00, 16'h8175});
      push_row({dev_kb, no_fault, 1'b1, 2'd1, 24'h1c0000, 8'h00, 16'h001c});
      push_row({dev_kb, bad_par, 1'b0, 2'd2, 24'hf01c00, 8'h00, 16'h0000});
      push_row({dev_kb, no_fault, 1'b1, 2'd1, 24'h1c0000, 8'h00, 16'h001c});
      push_row({dev_kb, truncated, 1'b0, 2'd1, 24'h5a0000, 8'h00, 16'h0000});
      push_row({dev_kb, no_fault, 1'b1, 2'd1, 24'h5a0000, 8'h00, 16'h005a});
      // pointer moves, buttons, negative dx
      push_row({dev_ms, no_fault, 1'b1, 2'd3, 24'h2864c0, 8'h00, 16'h0000});
      push_row({dev_ms, no_fault, 1'b1, 2'd3, 24'h0d0510, 8'h00, 16'h0000});
      push_row({dev_ms, no_fault, 1'b1, 2'd3, 24'h1af600, 8'h00, 16'h0000});
      push_row({dev_ms, no_fault, 1'b1, 2'd3, 24'h188000, 8'h00, 16'h0000});
      for (int k = 0; k < 5; k++)   // x up to the right edge
         push_row({dev_ms, no_fault, 1'b1, 2'd3, 24'h08ff00, 8'h00, 16'h0000});
      for (int k = 0; k < 6; k++)   // y down to the bottom edge
         push_row({dev_ms, no_fault, 1'b1, 2'd3, 24'h280080, 8'h00, 16'h0000});
      for (int k = 0; k < 7; k++)   // y back up to the top
         push_row({dev_ms, no_fault, 1'b1, 2'd3, 24'h08007f, 8'h00, 16'h0000});
      push_row({dev_ms, no_fault, 1'b1, 2'd3, 24'h7840e0, 8'h00, 16'h0000});
      push_row({dev_ms, no_fault, 1'b1, 2'd3, 24'h98f050, 8'h00, 16'h0000});
      // stray byte, then a packet, then both devices at once
      push_row({dev_ms, no_fault, 1'b0, 2'd1, 24'h410000, 8'h00, 16'h0000});
      push_row({dev_ms, no_fault, 1'b1, 2'd3, 24'h090203, 8'h00, 16'h0000});
      push_row({dev_both, no_fault, 1'b1, 2'd3, 24'h2c01ff, 8'h29, 16'h0029});
      rows_loaded = 1'b1;

      repeat (16) @(posedge clk);
      reset <= 1'b0;
      wait_cycles(4);

      foreach (rows[i]) begin
         r       = rows[i];
         kb_base = kb_count;
         ms_base = ms_count;
         send_row(r);
         if (r.strobe) begin
            if (r.dev != dev_ms) begin
               wait_strobe(dev_kb, kb_base);
               check_equal(32'(kb_seen), 32'(r.kb_exp), "kb_data");
            end
            if (r.dev != dev_kb) begin
               model_move(r.bytes);
               wait_strobe(dev_ms, ms_base);
               check_equal(32'(x_seen), model_x, "ms_x");
               check_equal(32'(y_seen), model_y, "ms_y");
               check_equal(32'(btn_seen), 32'(model_btn), "ms_button");
            end
            wait_cycles(60);
            check_equal(kb_count - kb_base, (r.dev != dev_ms) ? 1 : 0, "kb_ready pulses");
            check_equal(ms_count - ms_base, (r.dev != dev_kb) ? 1 : 0, "ms_ready pulses");
         end else begin
            wait_cycles(`PS2_TIMEOUT + 100);   // receiver must have given up by now
            if (kb_count != kb_base || ms_count != ms_base)
               abort_run("a ready strobe appeared for a frame that should be dropped");
         end
      end

      $display("Test completed successfully");
      $finish;
   end

   initial begin
      int limit;
      wait (rows_loaded);
      limit = rows.size() * row_cycles + 100;
      repeat (limit) @(posedge clk);
      abort_run("watchdog expired before all table rows finished");
   end

endmodule

`default_nettype wire

//--- ps2_support.f
+incdir+include
source/ps2_pkg.sv
source/ps2_rx.sv
source/kbd_decoder.sv
source/mouse_tracker.sv
source/kbms_regs.sv
source/ps2_support.sv
verification/ps2_support_tb.sv

//--- Makefile
# Verilator build for the PS/2 input block

TOP := ps2_support_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f ps2_support.f --top-module ps2_support
	verilator --lint-only --timing -f ps2_support.f --top-module $(TOP)

sim:
	verilator --binary --timing -f ps2_support.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
